// ==== source/snd_interp_defs.svh ====
`ifndef SND_INTERP_DEFS_SVH
`define SND_INTERP_DEFS_SVH

// Width of one signed audio sample
`define SND_SAMPLE_W 16

// Left and right channels
`define SND_CHANNELS 2

// Stereo output pair, left channel in the upper half
`define SND_PAIR_W (`SND_CHANNELS * `SND_SAMPLE_W)

`endif

// ==== source/snd_interp_pkg.sv ====
`include "snd_interp_defs.svh"

package snd_interp_pkg;

    // One signed audio sample
    typedef logic signed [`SND_SAMPLE_W-1:0] sample_t;

    // Up-by-two interpolator states
    // st_idle waits for a new input sample
    // st_mid holds the midpoint on the output
    // st_cur holds the current sample on the output
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mid  = 2'd1,
        st_cur  = 2'd2
    } interp_state_e;

endpackage

// ==== source/snd_upsample2.sv ====
`timescale 1ns/100ps
`include "snd_interp_defs.svh"

// Up-by-two linear interpolator for one audio channel.
// Every accepted sample produces the midpoint to the previous sample,
// then the sample itself. In bypass only the sample itself comes out.
module snd_upsample2
    import snd_interp_pkg::*;
(
    input  logic    snd_sample,
    input  logic    arst_n,
    input  logic    interp_en,
    // Input stream
    input  logic    in_valid,
    output logic    in_ready,
    input  sample_t in_sample,
    // Output stream
    output logic    out_valid,
    input  logic    out_ready,
    output sample_t out_sample
);

    interp_state_e state;
    interp_state_e state_nxt;

    // History, also the current sample once accepted
    sample_t cur_q;
    // Midpoint between history and the accepted sample
    sample_t mid_q;

    logic signed [`SND_SAMPLE_W:0] mid_sum;
    logic signed [`SND_SAMPLE_W:0] mid_shift;
    sample_t                       mid_calc;

    logic take_in;
    logic give_out;

    assign in_ready  = (state == st_idle);
    assign out_valid = (state != st_idle);

    assign take_in  = in_valid & in_ready;
    assign give_out = out_valid & out_ready;

    // Sum one bit wider so it cannot overflow
    assign mid_sum = {cur_q[`SND_SAMPLE_W-1], cur_q}
                   + {in_sample[`SND_SAMPLE_W-1], in_sample};

    // Arithmetic shift, rounds toward minus infinity
    assign mid_shift = mid_sum >>> 1;
    assign mid_calc  = mid_shift[`SND_SAMPLE_W-1:0];

    // Output word follows the state
    assign out_sample = (state == st_mid) ? mid_q : cur_q;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // interp_en is taken with the sample
                if (take_in) begin
                    state_nxt = interp_en ? st_mid : st_cur;
                end
            end
            st_mid: begin
                if (give_out) begin
                    state_nxt = st_cur;
                end
            end
            st_cur: begin
                if (give_out) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge snd_sample or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // History starts at zero, updated in bypass as well
    always_ff @(posedge snd_sample or negedge arst_n) begin
        if (!arst_n) begin
            cur_q <= '0;
        end else if (take_in) begin
            cur_q <= in_sample;
        end
    end

    always_ff @(posedge snd_sample) begin
        if (take_in) begin
            mid_q <= mid_calc;
        end
    end

endmodule

// ==== source/snd_stereo_join.sv ====
`timescale 1ns/100ps
`include "snd_interp_defs.svh"

// Joins the left and right channel streams into stereo pairs.
// Both channels are taken on the same edge, so they never drift apart.
module snd_stereo_join
    import snd_interp_pkg::*;
(
    input  logic                   snd_sample,
    input  logic                   arst_n,
    // Channel streams
    input  logic                   left_valid,
    input  logic                   right_valid,
    input  sample_t                left_sample,
    input  sample_t                right_sample,
    output logic                   pair_ready,
    // Stereo output
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`SND_PAIR_W-1:0] out_pair
);

    logic both_valid;
    logic out_free;
    logic take_pair;

    // Register free, or handed to the sink on this edge
    assign out_free   = ~out_valid | out_ready;
    assign both_valid = left_valid & right_valid;

    // One ready for both channels
    assign take_pair  = both_valid & out_free;
    assign pair_ready = take_pair;

    // Valid flag of the output register
    always_ff @(posedge snd_sample or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (take_pair) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Left in the upper half
    always_ff @(posedge snd_sample) begin
        if (take_pair) begin
            out_pair <= {left_sample, right_sample};
        end
    end

endmodule

// ==== source/snd_interp_top.sv ====
`timescale 1ns/100ps
`include "snd_interp_defs.svh"

// Stereo audio output stage: two up-by-two interpolators and a joiner
module snd_interp_top
    import snd_interp_pkg::*;
(
    input  logic                   snd_sample,
    input  logic                   arst_n,
    input  logic                   interp_en,
    // Stereo input
    input  logic                   in_valid,
    output logic                   in_ready,
    input  sample_t                in_left,
    input  sample_t                in_right,
    // Stereo output
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`SND_PAIR_W-1:0] out_pair
);

    logic    left_in_ready;
    logic    right_in_ready;
    logic    left_in_valid;
    logic    right_in_valid;

    logic    left_out_valid;
    logic    right_out_valid;
    sample_t left_out_sample;
    sample_t right_out_sample;
    logic    pair_ready;

    // Both channels take the same stereo sample on the same edge
    assign in_ready       = left_in_ready & right_in_ready;
    assign left_in_valid  = in_valid & right_in_ready;
    assign right_in_valid = in_valid & left_in_ready;

    snd_upsample2 u_left (
        .snd_sample ( snd_sample       ),
        .arst_n     ( arst_n           ),
        .interp_en  ( interp_en        ),
        .in_valid   ( left_in_valid    ),
        .in_ready   ( left_in_ready    ),
        .in_sample  ( in_left          ),
        .out_valid  ( left_out_valid   ),
        .out_ready  ( pair_ready       ),
        .out_sample ( left_out_sample  )
    );

    snd_upsample2 u_right (
        .snd_sample ( snd_sample       ),
        .arst_n     ( arst_n           ),
        .interp_en  ( interp_en        ),
        .in_valid   ( right_in_valid   ),
        .in_ready   ( right_in_ready   ),
        .in_sample  ( in_right         ),
        .out_valid  ( right_out_valid  ),
        .out_ready  ( pair_ready       ),
        .out_sample ( right_out_sample )
    );

    // Shared ready keeps both channels in step
    snd_stereo_join u_join (
        .snd_sample   ( snd_sample       ),
        .arst_n       ( arst_n           ),
        .left_valid   ( left_out_valid   ),
        .right_valid  ( right_out_valid  ),
        .left_sample  ( left_out_sample  ),
        .right_sample ( right_out_sample ),
        .pair_ready   ( pair_ready       ),
        .out_valid    ( out_valid        ),
        .out_ready    ( out_ready        ),
        .out_pair     ( out_pair         )
    );

endmodule

// ==== verification/snd_interp_checker.sv ====
`timescale 1ns/100ps
`include "snd_interp_defs.svh"

// Watches the ports of the audio interpolator and compares every output pair
// against pairs predicted from the accepted input samples
module snd_interp_checker
    import snd_interp_pkg::*;
(
    input  logic                   snd_sample,
    input  logic                   arst_n,
    input  logic                   interp_en,
    input  logic                   in_valid,
    input  logic                   in_ready,
    input  sample_t                in_left,
    input  sample_t                in_right,
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  logic [`SND_PAIR_W-1:0] out_pair,
    // Test control from the testbench top
    input  logic [2:0]             test_id,
    input  logic                   test_done,
    output int                     pending,
    output int                     checks,
    output int                     errors,
    output int                     tests
);

    // Expected output pairs, oldest first
    logic [`SND_PAIR_W-1:0] expect_q[$];
    logic [`SND_PAIR_W-1:0] exp_pair;

    // Reference history per channel
    sample_t hist_left;
    sample_t hist_right;

    int check_cnt = 0;
    int error_cnt = 0;
    int test_cnt = 0;
    int pend_cnt = 0;

    int test_checks = 0;
    int test_errors = 0;
    int test_inputs = 0;
    int test_outputs = 0;
    int test_expected = 0;

    assign pending = pend_cnt;
    assign checks  = check_cnt;
    assign errors  = error_cnt;
    assign tests   = test_cnt;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset_state";
            3'd2:    return "interp_ramp";
            3'd3:    return "random_backpressure";
            3'd4:    return "bypass";
            3'd5:    return "switch_mode";
            default: return "startup";
        endcase
    endfunction

    // Halfway point of two samples, rounded toward minus infinity
    function automatic sample_t midpoint(input sample_t prev, input sample_t cur);
        int sum;
        int half;
        sum = int'(prev) + int'(cur);
        if (sum >= 0) begin
            half = sum / 2;
        end else begin
            // Division truncates toward zero, so step down first
            half = (sum - 1) / 2;
        end
        return half[`SND_SAMPLE_W-1:0];
    endfunction

    task automatic report_fault(input string msg);
        error_cnt++;
        test_errors++;
        $display("ERROR in %s: %s", test_name(test_id), msg);
    endtask

    task automatic finish_test;
        if (test_outputs != test_expected) begin
            report_fault($sformatf("%0d output pairs seen but %0d expected",
                                   test_outputs, test_expected));
        end
        if (test_id == 3'd3 && test_outputs != 2 * test_inputs) begin
            report_fault("output count is not twice the input count");
        end
        if (test_id == 3'd4 && test_outputs != test_inputs) begin
            report_fault("bypass did not give one output pair per input");
        end
        $display("Test %s finished: %0d inputs, %0d outputs, %0d checks, %0d errors",
                 test_name(test_id), test_inputs, test_outputs, test_checks, test_errors);
        test_cnt++;
        test_checks   = 0;
        test_errors   = 0;
        test_inputs   = 0;
        test_outputs  = 0;
        test_expected = 0;
    endtask

    always @(posedge snd_sample) begin
        if (!arst_n) begin
            expect_q.delete();
            hist_left  = '0;
            hist_right = '0;
        end else begin
            // Idle state right after reset
            if (test_id == 3'd1) begin
                check_cnt++;
                test_checks++;
                if (out_valid !== 1'b0) begin
                    report_fault("out_valid is high after reset with no input");
                end
                if (in_ready !== 1'b1) begin
                    report_fault("in_ready is low after reset");
                end
            end

            // Output side first, the pair came from an earlier input
            if (out_valid && out_ready) begin
                test_outputs++;
                if (expect_q.size() == 0) begin
                    report_fault("output pair appeared with no input pending");
                end else begin
                    exp_pair = expect_q.pop_front();
                    check_cnt++;
                    test_checks++;
                    if (out_pair !== exp_pair) begin
                        error_cnt++;
                        test_errors++;
                        $display("FAILED %s: expected %h actual %h",
                                 test_name(test_id), exp_pair, out_pair);
                    end
                end
            end

            if (in_valid && in_ready) begin
                test_inputs++;
                if (interp_en) begin
                    expect_q.push_back({midpoint(hist_left, in_left),
                                        midpoint(hist_right, in_right)});
                    test_expected++;
                end
                expect_q.push_back({in_left, in_right});
                test_expected++;
                // History is kept in bypass too
                hist_left  = in_left;
                hist_right = in_right;
            end

            if (test_done) begin
                finish_test();
            end
        end
        pend_cnt = expect_q.size();
    end

endmodule

// ==== verification/snd_interp_tb.sv ====
`timescale 1ns/100ps
`include "snd_interp_defs.svh"

module snd_interp_tb
    import snd_interp_pkg::*;
();

    localparam int N_RAMP   = 10;
    localparam int N_RAND   = 64;
    localparam int N_BYP    = 16;
    localparam int N_SWITCH = 24;
    localparam int N_POOL   = N_RAND + N_BYP + N_SWITCH;
    localparam int N_TOTAL  = N_RAMP + N_POOL;
    // Ten cycles per sample, plus reset and drain margin
    localparam int TIMEOUT_CYCLES = N_TOTAL * 10 + 200;

    logic                   snd_sample;
    logic                   arst_n;
    logic                   interp_en;
    logic                   in_valid;
    logic                   in_ready;
    sample_t                in_left;
    sample_t                in_right;
    logic                   out_valid;
    logic                   out_ready;
    logic [`SND_PAIR_W-1:0] out_pair;

    logic [2:0]  test_id;
    logic        test_done;
    logic        random_ready;
    int          pending;
    int          checks;
    int          errors;
    int          tests;
    int          seed;
    logic [31:0] ready_rnd;
    logic [31:0] rand_data [0:N_POOL-1];

    snd_interp_top i_snd_interp_top (
        .snd_sample ( snd_sample ),
        .arst_n     ( arst_n     ),
        .interp_en  ( interp_en  ),
        .in_valid   ( in_valid   ),
        .in_ready   ( in_ready   ),
        .in_left    ( in_left    ),
        .in_right   ( in_right   ),
        .out_valid  ( out_valid  ),
        .out_ready  ( out_ready  ),
        .out_pair   ( out_pair   )
    );

    snd_interp_checker u_checker (
        .snd_sample ( snd_sample ),
        .arst_n     ( arst_n     ),
        .interp_en  ( interp_en  ),
        .in_valid   ( in_valid   ),
        .in_ready   ( in_ready   ),
        .in_left    ( in_left    ),
        .in_right   ( in_right   ),
        .out_valid  ( out_valid  ),
        .out_ready  ( out_ready  ),
        .out_pair   ( out_pair   ),
        .test_id    ( test_id    ),
        .test_done  ( test_done  ),
        .pending    ( pending    ),
        .checks     ( checks     ),
        .errors     ( errors     ),
        .tests      ( tests      )
    );

    initial begin
        snd_sample = 1'b0;
        forever #10 snd_sample = ~snd_sample;
    end

    // Sink ready, random while random_ready is set
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge snd_sample);
            #2;
            if (random_ready) begin
                ready_rnd = $random(seed);
                out_ready = ready_rnd[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge snd_sample);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    function automatic sample_t ramp_sample(input int base, input int step, input int idx);
        int v;
        v = base + step * idx;
        return v[`SND_SAMPLE_W-1:0];
    endfunction

    // Called 2 ns after a rising edge, returns at the same point
    task automatic send_sample(input sample_t left, input sample_t right, input logic en);
        logic taken;
        in_left   = left;
        in_right  = right;
        interp_en = en;
        in_valid  = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge snd_sample);
            taken = in_ready;
            @(posedge snd_sample);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain;
        while (pending != 0 || out_valid) begin
            @(posedge snd_sample);
            #2;
        end
    endtask

    task automatic end_test;
        test_done = 1'b1;
        @(posedge snd_sample);
        #2;
        test_done = 1'b0;
    endtask

    initial begin
        seed = 32'h196;
        for (int k = 0; k < N_POOL; k++) begin
            rand_data[k] = $random(seed);
        end
        arst_n       = 1'b0;
        interp_en    = 1'b1;
        in_valid     = 1'b0;
        in_left      = '0;
        in_right     = '0;
        test_id      = 3'd0;
        test_done    = 1'b0;
        random_ready = 1'b0;

        repeat (3) @(posedge snd_sample);
        #2;
        arst_n = 1'b1;

        // Quiet after reset
        test_id = 3'd1;
        repeat (6) @(posedge snd_sample);
        #2;
        end_test();

        // Ramp, ending on the full-scale jump
        test_id = 3'd2;
        for (int i = 0; i < N_RAMP - 2; i++) begin
            send_sample(ramp_sample(123, 3001, i), ramp_sample(-55, -2749, i), 1'b1);
        end
        send_sample(16'h7fff, 16'h8000, 1'b1);
        send_sample(16'h8000, 16'h7fff, 1'b1);
        wait_drain();
        end_test();

        test_id = 3'd3;
        @(negedge snd_sample);
        random_ready = 1'b1;
        @(posedge snd_sample);
        #2;
        for (int i = 0; i < N_RAND; i++) begin
            send_sample(rand_data[i][31:16], rand_data[i][15:0], 1'b1);
        end
        wait_drain();
        @(negedge snd_sample);
        random_ready = 1'b0;
        @(posedge snd_sample);
        #2;
        end_test();

        test_id = 3'd4;
        for (int i = N_RAND; i < N_RAND + N_BYP; i++) begin
            send_sample(rand_data[i][31:16], rand_data[i][15:0], 1'b0);
        end
        wait_drain();
        end_test();

        // Three bypassed, three interpolated, and so on
        test_id = 3'd5;
        @(negedge snd_sample);
        random_ready = 1'b1;
        @(posedge snd_sample);
        #2;
        for (int i = 0; i < N_SWITCH; i++) begin
            send_sample(rand_data[N_RAND + N_BYP + i][31:16],
                        rand_data[N_RAND + N_BYP + i][15:0], (i % 6) >= 3);
        end
        wait_drain();
        end_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0 && tests == 5 && checks > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== snd_interp.f ====
+incdir+source
source/snd_interp_pkg.sv
source/snd_upsample2.sv
source/snd_stereo_join.sv
source/snd_interp_top.sv
verification/snd_interp_checker.sv
verification/snd_interp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the audio interpolator testbench with Verilator and runs it.
# The result is taken from the pass line in the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing \
    --top-module snd_interp_tb \
    -f snd_interp.f \
    -o snd_interp_sim > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Verilator build failed"; exit 1; }

./obj_dir/snd_interp_sim > "$SIM_LOG" 2>&1 \
    || { cat "$SIM_LOG"; echo "Simulation run ended with an error"; exit 1; }

cat "$SIM_LOG"

grep -qxF '** PASS **' "$SIM_LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
